//--- logic/pb_bridge_settings.svh
`ifndef PB_BRIDGE_SETTINGS_SVH
`define PB_BRIDGE_SETTINGS_SVH

// Command line storage, bytes past the end are dropped
`define PB_CMD_BUF_LEN 32

// Opcode characters including the trailing comma
`define PB_OPCODE_LEN 11

// Parameter bytes per command and response bytes per read
`define PB_NUM_PARAMS 4

// Cycles the read or write strobe stays asserted
`define PB_STROBE_CYCLES 2

// Status codes printed after each command
`define PB_STATUS_PASS 8'h56
`define PB_STATUS_FAIL 8'hFE

`endif

//--- logic/pb_bridge_pkg.sv
package pb_bridge_pkg;

`include "pb_bridge_settings.svh"

    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_WRITE = 2'd1,
        OP_READ  = 2'd2
    } opcode_t;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_SETUP,                          // Address and enable, no strobe
        BUS_STROBE,
        BUS_GAP                             // Idle cycle between bytes
    } bus_state_t;

    typedef enum logic {
        RX_COLLECT,
        RX_BUSY                             // Command in flight
    } rx_state_t;

    typedef struct packed {
        opcode_t                        op;
        logic [`PB_NUM_PARAMS-1:0][7:0] params; // Index 0 goes to address 0
    } bus_cmd_t;

    typedef struct packed {
        opcode_t                        op;
        logic [`PB_NUM_PARAMS-1:0][7:0] data;   // All zero after a write
    } bus_result_t;

    typedef struct packed {
        logic       valid;
        logic       last;                   // Final byte of a line
        logic [7:0] data;
    } tx_req_t;

    localparam logic [8*`PB_OPCODE_LEN-1:0] WRITE_TEXT = "pb_i_write,";
    localparam logic [8*`PB_OPCODE_LEN-1:0] READ_TEXT  = "pb_i__read,";

    function automatic logic [7:0] nibble_to_ascii(input logic [3:0] n);
        return (n < 4'd10) ? 8'h30 + {4'h0, n} : 8'h37 + {4'h0, n}; // Upper case
    endfunction

endpackage

//--- logic/cmd_receiver.sv
`timescale 1ns/10ps
`include "pb_bridge_settings.svh"

module cmd_receiver (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [7:0]              rx_data,
    input  logic                    rx_valid,
    input  logic                    rx_packet_end,
    input  logic                    line_done,
    output logic                    cmd_start,
    output logic                    cmd_bad,
    output pb_bridge_pkg::bus_cmd_t cmd
);
    import pb_bridge_pkg::*;

    localparam int IDX_W   = $clog2(`PB_CMD_BUF_LEN);
    localparam int CNT_W   = $clog2(`PB_CMD_BUF_LEN + 1);
    localparam int MIN_LEN = `PB_OPCODE_LEN + 2 * `PB_NUM_PARAMS;

    rx_state_t                      state;
    logic [7:0]                     cmd_buf [`PB_CMD_BUF_LEN];
    logic [CNT_W-1:0]               byte_count;
    logic                           store;
    logic [8*`PB_OPCODE_LEN-1:0]    opcode_word;
    opcode_t                        decoded_op;
    logic [`PB_NUM_PARAMS-1:0][7:0] parsed_params;
    logic                           digits_ok;
    logic                           cmd_ok;

    // Returns {valid, nibble}
    function automatic logic [4:0] ascii_to_nibble(input logic [7:0] c);
        if (c >= "0" && c <= "9") return {1'b1, 4'(c - 8'h30)};
        if (c >= "A" && c <= "F") return {1'b1, 4'(c - 8'h37)};
        if (c >= "a" && c <= "f") return {1'b1, 4'(c - 8'h57)};
        return 5'h00;
    endfunction

    assign store = (state == RX_COLLECT) && rx_valid && (byte_count < CNT_W'(`PB_CMD_BUF_LEN));

    always_ff @(posedge clock) begin
        if (store) begin
            cmd_buf[byte_count[IDX_W-1:0]] <= rx_data;
        end
    end

    always_comb begin : decode
        logic [4:0] nib;
        nib = '0;
        digits_ok = 1'b1;
        parsed_params = '0;
        for (int i = 0; i < `PB_OPCODE_LEN; i++) begin
            opcode_word[8*(`PB_OPCODE_LEN-1-i) +: 8] = cmd_buf[i]; // First char in MSBs
        end
        // Parameters always start right after the comma
        for (int i = 0; i < 2 * `PB_NUM_PARAMS; i++) begin
            nib = ascii_to_nibble(cmd_buf[`PB_OPCODE_LEN + i]);
            digits_ok = digits_ok && nib[4];
            parsed_params[i/2][4*(1 - i%2) +: 4] = nib[3:0]; // High nibble first
        end
        if (opcode_word == WRITE_TEXT) begin
            decoded_op = OP_WRITE;
        end else if (opcode_word == READ_TEXT) begin
            decoded_op = OP_READ;
        end else begin
            decoded_op = OP_NONE;
        end
        cmd_ok = (decoded_op != OP_NONE) && digits_ok && (byte_count >= CNT_W'(MIN_LEN));
    end

    always_ff @(posedge clock) begin
        cmd_start <= 1'b0;
        cmd_bad   <= 1'b0;
        if (reset) begin
            state      <= RX_COLLECT;
            byte_count <= '0;
        end else begin
            case (state)
                RX_COLLECT: begin
                    if (rx_packet_end) begin
                        cmd_start  <= cmd_ok;
                        cmd_bad    <= !cmd_ok;
                        byte_count <= '0;
                        state      <= RX_BUSY;
                    end else if (store) begin
                        byte_count <= byte_count + 1'b1;
                    end
                end
                RX_BUSY: begin
                    if (line_done) begin
                        state <= RX_COLLECT;    // Status line is out
                    end
                end
                default: state <= RX_COLLECT;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == RX_COLLECT && rx_packet_end) begin
            cmd.op     <= decoded_op;
            cmd.params <= parsed_params;
        end
    end

    a_start_xor_bad: assert property (@(posedge clock) disable iff (reset)
        !(cmd_start && cmd_bad));

endmodule

//--- logic/pb_bus_engine.sv
`timescale 1ns/10ps
`include "pb_bridge_settings.svh"

module pb_bus_engine (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       cmd_start,
    input  pb_bridge_pkg::bus_cmd_t    cmd,
    input  logic [7:0]                 pb_data_in,
    output logic [2:0]                 pb_addr,
    output logic [7:0]                 pb_data_out,
    output logic                       pb_data_oe,
    output logic                       pb_rd,
    output logic                       pb_wr,
    output logic                       bus_done,
    output pb_bridge_pkg::bus_result_t result
);
    import pb_bridge_pkg::*;

    localparam int BI_W = $clog2(`PB_NUM_PARAMS);
    localparam int SC_W = $clog2(`PB_STROBE_CYCLES + 1);

    bus_state_t       state;
    bus_cmd_t         cur_cmd;
    logic [BI_W-1:0]  byte_idx;
    logic [SC_W-1:0]  strobe_cnt;
    logic             strobe_last;
    logic             last_byte;

    assign strobe_last = (strobe_cnt == SC_W'(`PB_STROBE_CYCLES - 1));
    assign last_byte   = (byte_idx == BI_W'(`PB_NUM_PARAMS - 1));

    always_ff @(posedge clock) begin
        bus_done <= 1'b0;
        if (reset) begin
            state      <= BUS_IDLE;
            byte_idx   <= '0;
            strobe_cnt <= '0;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (cmd_start) begin
                        byte_idx <= '0;
                        state    <= BUS_SETUP;
                    end
                end
                BUS_SETUP: begin
                    strobe_cnt <= '0;
                    state      <= BUS_STROBE;
                end
                BUS_STROBE: begin
                    if (strobe_last) begin
                        bus_done <= last_byte;  // Lands in the final idle cycle
                        state    <= BUS_GAP;
                    end else begin
                        strobe_cnt <= strobe_cnt + 1'b1;
                    end
                end
                BUS_GAP: begin
                    if (last_byte) begin
                        state <= BUS_IDLE;
                    end else begin
                        byte_idx <= byte_idx + 1'b1;
                        state    <= BUS_SETUP;
                    end
                end
                default: state <= BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == BUS_IDLE && cmd_start) begin
            cur_cmd     <= cmd;
            result.op   <= cmd.op;
            result.data <= '0;
        end else if (state == BUS_STROBE && strobe_last && cur_cmd.op == OP_READ) begin
            result.data[byte_idx] <= pb_data_in; // Sample on last strobe cycle
        end
    end

    assign pb_addr     = 3'(byte_idx);
    assign pb_data_out = cur_cmd.params[byte_idx];
    assign pb_data_oe  = (cur_cmd.op == OP_WRITE) && (state == BUS_SETUP || state == BUS_STROBE);
    assign pb_rd       = (state == BUS_STROBE) && (cur_cmd.op == OP_READ);
    assign pb_wr       = (state == BUS_STROBE) && (cur_cmd.op == OP_WRITE);

    a_rd_wr_excl: assert property (@(posedge clock) disable iff (reset) !(pb_rd && pb_wr));

    // Device drives the bus during a read
    a_no_oe_on_rd: assert property (@(posedge clock) disable iff (reset) pb_rd |-> !pb_data_oe);

endmodule

//--- logic/reply_writer.sv
`timescale 1ns/10ps
`include "pb_bridge_settings.svh"

module reply_writer (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       bus_done,
    input  pb_bridge_pkg::bus_result_t result,
    input  logic                       grant,
    input  logic                       tx_full,
    output pb_bridge_pkg::tx_req_t     req
);
    import pb_bridge_pkg::*;

    localparam int WRITE_LEN = `PB_OPCODE_LEN + 2 + 2;                   // "OK" then CR LF
    localparam int READ_LEN  = `PB_OPCODE_LEN + 2 * `PB_NUM_PARAMS + 2;
    localparam int PW        = $clog2(`PB_NUM_PARAMS);

    bus_result_t                 line;
    logic                        pending;
    logic [4:0]                  idx;
    logic [4:0]                  line_len;
    logic [4:0]                  digit;
    logic [8*`PB_OPCODE_LEN-1:0] op_text;
    logic [7:0]                  ch;
    logic                        send;

    assign line_len = (line.op == OP_WRITE) ? 5'(WRITE_LEN) : 5'(READ_LEN);
    assign op_text  = (line.op == OP_WRITE) ? WRITE_TEXT : READ_TEXT;
    assign digit    = idx - 5'(`PB_OPCODE_LEN);
    assign send     = pending && grant && !tx_full;

    always_comb begin
        if (idx < 5'(`PB_OPCODE_LEN)) begin
            ch = op_text[8*(`PB_OPCODE_LEN-1-idx) +: 8];
        end else if (idx == line_len - 5'd2) begin
            ch = 8'h0D;
        end else if (idx == line_len - 5'd1) begin
            ch = 8'h0A;
        end else if (line.op == OP_WRITE) begin
            ch = (idx == 5'(`PB_OPCODE_LEN)) ? "O" : "K";
        end else if (digit[0]) begin
            ch = nibble_to_ascii(line.data[digit[PW:1]][3:0]);
        end else begin
            ch = nibble_to_ascii(line.data[digit[PW:1]][7:4]); // Byte 0 printed first
        end
    end

    always_comb begin
        req.valid = pending;
        req.last  = (idx == line_len - 5'd1);
        req.data  = ch;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= 1'b0;
            idx     <= '0;
        end else if (bus_done) begin
            pending <= 1'b1;
            idx     <= '0;
        end else if (send) begin
            idx <= idx + 1'b1;
            if (req.last) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (bus_done) begin
            line <= result;                 // Held for the whole line
        end
    end

    // One command in flight, so the previous reply must be out
    a_no_overrun: assert property (@(posedge clock) disable iff (reset) bus_done |-> !pending);

endmodule

//--- logic/status_writer.sv
`timescale 1ns/10ps
`include "pb_bridge_settings.svh"

module status_writer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   pass_start,
    input  logic                   fail_start,
    input  logic                   grant,
    input  logic                   tx_full,
    output pb_bridge_pkg::tx_req_t req,
    output logic                   line_done
);
    import pb_bridge_pkg::*;

    localparam logic [8*7-1:0] PASS_TEXT = "Pass 0x";
    localparam logic [8*9-1:0] FAIL_TEXT = "Failed 0x";

    logic       pending;
    logic       is_fail;
    logic [7:0] code;
    logic [3:0] idx;
    logic [3:0] prefix_len;
    logic [7:0] ch;
    logic       send;

    assign prefix_len = is_fail ? 4'd9 : 4'd7;
    assign send       = pending && grant && !tx_full;

    always_comb begin
        if (idx < prefix_len) begin
            if (is_fail) begin
                ch = FAIL_TEXT[8*(8-idx) +: 8];
            end else begin
                ch = PASS_TEXT[8*(6-idx) +: 8];
            end
        end else if (idx == prefix_len) begin
            ch = nibble_to_ascii(code[7:4]);
        end else if (idx == prefix_len + 4'd1) begin
            ch = nibble_to_ascii(code[3:0]);
        end else if (idx == prefix_len + 4'd2) begin
            ch = 8'h0D;
        end else begin
            ch = 8'h0A;                     // Line ends on LF
        end
    end

    always_comb begin
        req.valid = pending;
        req.last  = (idx == prefix_len + 4'd3);
        req.data  = ch;
    end

    always_ff @(posedge clock) begin
        line_done <= 1'b0;
        if (reset) begin
            pending <= 1'b0;
            idx     <= '0;
        end else if (pass_start || fail_start) begin
            pending <= 1'b1;
            idx     <= '0;
        end else if (send) begin
            idx <= idx + 1'b1;
            if (req.last) begin
                pending   <= 1'b0;
                line_done <= 1'b1;          // Frees the receiver
            end
        end
    end

    always_ff @(posedge clock) begin
        if (pass_start || fail_start) begin
            is_fail <= fail_start;
            code    <= fail_start ? `PB_STATUS_FAIL : `PB_STATUS_PASS;
        end
    end

endmodule

//--- logic/tx_arbiter.sv
`timescale 1ns/10ps

module tx_arbiter (
    input  logic                   clock,
    input  logic                   reset,
    input  pb_bridge_pkg::tx_req_t reply_req,
    input  pb_bridge_pkg::tx_req_t status_req,
    input  logic                   tx_full,
    output logic                   reply_grant,
    output logic                   status_grant,
    output logic                   tx_write,
    output logic [7:0]             tx_data
);
    import pb_bridge_pkg::*;

    logic owner_reply;                      // Line in progress from reply writer
    logic owner_status;
    logic tx_last;

    // Fixed priority when nobody owns the port, reply first
    always_comb begin
        reply_grant  = owner_reply || (!owner_status && reply_req.valid);
        status_grant = owner_status || (!owner_reply && !reply_req.valid && status_req.valid);
    end

    assign tx_write = !tx_full && ((reply_grant && reply_req.valid) ||
                                   (status_grant && status_req.valid));
    assign tx_data  = reply_grant ? reply_req.data : status_req.data;
    assign tx_last  = reply_grant ? reply_req.last : status_req.last;

    always_ff @(posedge clock) begin
        if (reset) begin
            owner_reply  <= 1'b0;
            owner_status <= 1'b0;
        end else if (tx_write) begin
            owner_reply  <= reply_grant && !tx_last;    // Hold until last byte
            owner_status <= status_grant && !tx_last;
        end
    end

    a_one_grant: assert property (@(posedge clock) disable iff (reset)
        !(reply_grant && status_grant));

endmodule

//--- logic/pb_bridge_top.sv
`timescale 1ns/10ps

module pb_bridge_top (
    input  logic       clock,
    input  logic       reset,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       rx_packet_end,
    input  logic       tx_full,
    input  logic [7:0] pb_data_in,
    output logic [7:0] tx_data,
    output logic       tx_write,
    output logic [2:0] pb_addr,
    output logic [7:0] pb_data_out,
    output logic       pb_data_oe,
    output logic       pb_rd,
    output logic       pb_wr
);
    import pb_bridge_pkg::*;

    bus_cmd_t    cmd;
    bus_result_t result;
    tx_req_t     reply_req;
    tx_req_t     status_req;
    logic        cmd_start;
    logic        cmd_bad;
    logic        bus_done;
    logic        line_done;
    logic        reply_grant;
    logic        status_grant;

    cmd_receiver u_cmd_receiver (
        .clock, .reset, .rx_data, .rx_valid, .rx_packet_end, .line_done,
        .cmd_start, .cmd_bad, .cmd
    );

    pb_bus_engine u_bus_engine (
        .clock, .reset, .cmd_start, .cmd, .pb_data_in,
        .pb_addr, .pb_data_out, .pb_data_oe, .pb_rd, .pb_wr, .bus_done, .result
    );

    reply_writer u_reply_writer (
        .clock, .reset, .bus_done, .result, .grant(reply_grant), .tx_full, .req(reply_req)
    );

    status_writer u_status_writer (
        .clock, .reset,
        .pass_start(bus_done),              // Pass line follows every reply
        .fail_start(cmd_bad),
        .grant(status_grant), .tx_full, .req(status_req), .line_done
    );

    tx_arbiter u_tx_arbiter (
        .clock, .reset, .reply_req, .status_req, .tx_full,
        .reply_grant, .status_grant, .tx_write, .tx_data
    );

endmodule

//--- verification/pb_bridge_tb.sv
`timescale 1ns/10ps

module pb_bridge_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int MAX_GAP         = 3;     // Idle cycles between command bytes
    localparam int MAX_STALL       = 4;     // Longest run of tx_full high
    localparam int STROBE_CYCLES   = 8;     // Four bytes, two strobe cycles each
    localparam int OE_CYCLES       = 12;    // Setup plus two strobe cycles per written byte
    localparam int NUM_TESTS       = 27;
    localparam int CYCLES_PER_TEST = 32 * (MAX_STALL + 1) + 20 * (MAX_GAP + 2) + 60;
    localparam int WATCHDOG_NS     = (NUM_TESTS * CYCLES_PER_TEST + 50) * CLK_PERIOD;

    logic       clock;
    logic       reset;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic       rx_packet_end;
    logic       tx_full = 1'b0;
    logic [7:0] pb_data_in = 8'h00;
    logic [7:0] tx_data;
    logic       tx_write;
    logic [2:0] pb_addr;
    logic [7:0] pb_data_out;
    logic       pb_data_oe;
    logic       pb_rd;
    logic       pb_wr;

    integer      seed = 68;
    integer      stall_seed = 68;
    logic [31:0] stall_rand;
    int          stall_run = 0;
    logic        full_enable = 1'b0;

    logic [7:0] dev_mem [4] = '{8'h00, 8'h00, 8'h00, 8'h00};   // Bus device contents
    logic [7:0] ref_mem [4] = '{8'h00, 8'h00, 8'h00, 8'h00};   // What the commands wrote
    logic [7:0] cmd_q [$];
    logic [7:0] exp_q [$];
    logic [7:0] got_q [$];                  // Every byte the host has received
    int         strobe_count = 0;
    int         oe_count = 0;
    int         full_writes = 0;            // Bytes written while the port was full
    int         errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;

    pb_bridge_top dut (
        .clock, .reset, .rx_data, .rx_valid, .rx_packet_end, .tx_full, .pb_data_in,
        .tx_data, .tx_write, .pb_addr, .pb_data_out, .pb_data_oe, .pb_rd, .pb_wr
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the bridge stopped answering", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Host receive side and bus device write side
    always @(posedge clock) begin
        if (!reset) begin
            if (tx_write) got_q.push_back(tx_data);
            if (tx_write && tx_full) full_writes++;
            if (pb_rd || pb_wr) strobe_count++;
            if (pb_data_oe) oe_count++;
            if (pb_wr) dev_mem[pb_addr[1:0]] <= pb_data_out;
        end
    end

    always @(negedge clock) begin
        pb_data_in = pb_rd ? dev_mem[pb_addr[1:0]] : 8'h00;   // Device drives during a read
        stall_rand = $random(stall_seed);
        if (full_enable && stall_run < MAX_STALL && stall_rand[0]) begin
            tx_full = 1'b1;
            stall_run++;
        end else begin
            tx_full   = 1'b0;
            stall_run = 0;
        end
    end

    function automatic logic [7:0] hex_char(input logic [3:0] n, input bit lower);
        if (n < 4'd10) return 8'h30 + 8'(n);
        return (lower ? 8'h61 : 8'h41) + 8'(n) - 8'd10;
    endfunction

    task automatic push_text(input string s);
        for (int i = 0; i < s.len(); i++) exp_q.push_back(s[i]);
    endtask

    task automatic push_line_end();
        exp_q.push_back(8'h0D);
        exp_q.push_back(8'h0A);
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_base);
        tests_run++;
        if (errors == err_base) begin
            $display("Test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed", tests_run, name);
        end
    endtask

    task automatic send_line();
        int gap;
        foreach (cmd_q[i]) begin
            gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            repeat (gap) @(negedge clock);
            rx_data  = cmd_q[i];
            rx_valid = 1'b1;
            @(negedge clock);
            rx_valid = 1'b0;
        end
        rx_packet_end = 1'b1;
        @(negedge clock);
        rx_packet_end = 1'b0;
    endtask

    // flaw 1 breaks the opcode, flaw 2 puts a non-hex digit in the parameters
    task automatic run_command(input string name, input bit is_read, input bit lower,
                               input int flaw);
        string      op_text;
        logic [7:0] params [4];
        int         base;
        int         strobe_base;
        int         oe_base;
        int         full_base;
        int         err_base;
        int         pos;
        op_text     = is_read ? "pb_i__read," : "pb_i_write,";
        err_base    = errors;
        base        = got_q.size();
        strobe_base = strobe_count;
        oe_base     = oe_count;
        full_base   = full_writes;
        cmd_q.delete();
        exp_q.delete();
        foreach (params[i]) params[i] = 8'($random(seed));
        for (int i = 0; i < 11; i++) cmd_q.push_back(op_text[i]);
        for (int i = 0; i < 8; i++) begin
            cmd_q.push_back(hex_char((i % 2 == 1) ? params[i/2][3:0] : params[i/2][7:4], lower));
        end
        if (flaw == 1) begin
            pos = $unsigned($random(seed)) % 10;
            cmd_q[pos] = cmd_q[pos] ^ 8'h20;
        end else if (flaw == 2) begin
            pos = 11 + $unsigned($random(seed)) % 8;
            cmd_q[pos] = 8'h67 + 8'($unsigned($random(seed)) % 20);   // g to z
        end
        if (flaw != 0) begin
            push_text("Failed 0xFE");
            push_line_end();
        end else begin
            push_text(op_text);
            if (is_read) begin
                foreach (ref_mem[i]) begin
                    exp_q.push_back(hex_char(ref_mem[i][7:4], 1'b0));
                    exp_q.push_back(hex_char(ref_mem[i][3:0], 1'b0));
                end
            end else begin
                push_text("OK");
                foreach (ref_mem[i]) ref_mem[i] = params[i];
            end
            push_line_end();
            push_text("Pass 0x56");
            push_line_end();
        end
        send_line();
        while (got_q.size() - base < exp_q.size()) @(negedge clock);
        repeat (4) @(negedge clock);        // Receiver rearms after line_done
        compare({name, " length"}, exp_q.size(), got_q.size() - base);
        foreach (exp_q[i]) compare($sformatf("%s byte %0d", name, i), exp_q[i], got_q[base + i]);
        compare({name, " strobe cycles"}, (flaw == 0) ? STROBE_CYCLES : 0,
                strobe_count - strobe_base);
        compare({name, " oe cycles"}, (flaw == 0 && !is_read) ? OE_CYCLES : 0,
                oe_count - oe_base);
        compare({name, " writes while full"}, 0, full_writes - full_base);
        if (flaw == 0 && !is_read) begin
            foreach (dev_mem[i]) compare($sformatf("%s mem %0d", name, i), params[i], dev_mem[i]);
        end
        finish_test(name, err_base);
    endtask

    task automatic check_silent(input string name);
        int err_base;
        int base;
        int strobe_base;
        int oe_base;
        err_base    = errors;
        base        = got_q.size();
        strobe_base = strobe_count;
        oe_base     = oe_count;
        repeat (20) @(negedge clock);
        compare({name, " tx bytes"}, 0, got_q.size() - base);
        compare({name, " strobe cycles"}, 0, strobe_count - strobe_base);
        compare({name, " oe cycles"}, 0, oe_count - oe_base);
        finish_test(name, err_base);
    endtask

    initial begin
        logic [31:0] r;
        reset         = 1'b1;
        rx_data       = 8'h00;
        rx_valid      = 1'b0;
        rx_packet_end = 1'b0;
        repeat (5) @(negedge clock);
        reset = 1'b0;
        check_silent("reset_idle");
        full_enable = 1'b1;
        run_command("write_upper", 1'b0, 1'b0, 0);
        run_command("write_lower", 1'b0, 1'b1, 0);
        run_command("read_back", 1'b1, 1'b0, 0);   // Must show the lower-case write
        run_command("bad_opcode", 1'b1, 1'b0, 1);
        run_command("bad_digit", 1'b0, 1'b1, 2);
        for (int i = 0; i < 20; i++) begin
            r = $random(seed);
            run_command($sformatf("random_%0d", i), r[0], r[1],
                        (r[4:2] == 3'd0) ? 1 : ((r[4:2] == 3'd1) ? 2 : 0));
        end
        check_silent("quiet_after");       // Nothing repeated after the last line
        $display("Tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+logic
logic/pb_bridge_pkg.sv
logic/cmd_receiver.sv
logic/pb_bus_engine.sv
logic/reply_writer.sv
logic/status_writer.sv
logic/tx_arbiter.sv
logic/pb_bridge_top.sv
verification/pb_bridge_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=pb_bridge_sim

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module pb_bridge_tb -f all.f -o "$BIN"; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/"$BIN" > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error"
    exit 1
fi

cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "Testbench reported a failure"
    exit 1
fi

echo "Testbench run completed without failure"
exit 0
